// ==== dv/t08_mmio_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "t08_defines.svh"

module t08_mmio_tb;

    import t08_pkg::*;

    localparam int SPI_TIMEOUT  = 1000;  // clocks, longest transfer is 80
    localparam int QUIET_CYCLES = 20;    // window that must stay idle after a transfer
    localparam int CHK_NONE     = 0;
    localparam int CHK_TABLE    = 1;     // expected value from the table
    localparam int CHK_MEM      = 2;     // expected value from the memory model
    localparam logic [31:0] A_CMD   = `T08_SPI_ADDR_CMD;
    localparam logic [31:0] A_PARAM = `T08_SPI_ADDR_PARAM;
    localparam logic [31:0] A_I2C   = `T08_I2C_ADDR;

    typedef enum {OP_IDLE, OP_WR, OP_RD, OP_FETCH, OP_RW, OP_SPI_WAIT} op_e;

    typedef struct {
        op_e         op;
        logic [31:0] addr;
        logic [31:0] data;
        bit          rnd;       // take data from the lcg instead
        logic [31:0] xy;
        bit          done;
        logic [31:0] exp;
        int          chk;
    } step_t;

    logic        clk;
    logic        rst_n_i;
    logic        read_i;
    logic        write_i;
    logic        getinst_i;
    logic [31:0] address_i;
    logic [31:0] wdata_i;
    logic [31:0] i2c_xy_i;
    logic        i2c_done_i;
    logic [31:0] rdata_o;
    logic        busy_o;
    logic        i2c_done_o;
    logic        spi_busy_o;
    logic        spi_sck_o;
    logic        spi_mosi_o;
    logic        spi_cs_n_o;

    step_t       steps_q[$];
    logic [31:0] mem_model [512];   // word model, index = addr[10:2]
    int          mem_cnt;           // model of the busy window
    bit          spi_active;
    logic [7:0]  cmd_m;
    logic [3:0]  cnt_m;
    bit          exp_bits[$];
    bit          got_bits[$];       // filled by the line monitor
    logic [31:0] lcg_state;
    int          value_errs;
    int          proto_errs;

    t08_tb_clk u_clk (.clk_o(clk));

    t08_mmio_top dut_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .read_i     (read_i),
        .write_i    (write_i),
        .getinst_i  (getinst_i),
        .address_i  (address_i),
        .wdata_i    (wdata_i),
        .i2c_xy_i   (i2c_xy_i),
        .i2c_done_i (i2c_done_i),
        .rdata_o    (rdata_o),
        .busy_o     (busy_o),
        .i2c_done_o (i2c_done_o),
        .spi_busy_o (spi_busy_o),
        .spi_sck_o  (spi_sck_o),
        .spi_mosi_o (spi_mosi_o),
        .spi_cs_n_o (spi_cs_n_o)
    );

    // spi line monitor, data taken on sck rise
    always @(posedge spi_sck_o) begin
        if (spi_cs_n_o) begin
            proto_errs++;
            $display("spi clock rose while chip select was high at %0t", $time);
        end
        got_bits.push_back(spi_mosi_o);
    end

    always @(negedge clk) begin
        if (rst_n_i && spi_busy_o && spi_cs_n_o) begin
            proto_errs++;
            $display("chip select went high during a transfer at %0t", $time);
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // address map as the decoder should see it
    function automatic mmio_target_e classify(input logic [31:0] a);
        if (a == `T08_I2C_ADDR)
            return TGT_I2C;
        if (a == `T08_SPI_ADDR_CMD)
            return TGT_SPI_CMD;
        if (a == `T08_SPI_ADDR_PARAM)
            return TGT_SPI_PARAM;
        if (a < `T08_MEM_LIMIT)
            return TGT_MEM;
        return TGT_NONE;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic push_byte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--)
            exp_bits.push_back(b[i]);   // msb first
    endtask

    // command byte, then up to four parameter bytes from byte 0
    task automatic model_spi_start(input logic [31:0] params);
        int n;
        n = (cnt_m > `T08_SPI_MAX_BYTES) ? `T08_SPI_MAX_BYTES : int'(cnt_m);
        push_byte(cmd_m);
        for (int k = 0; k < n; k++)
            push_byte(params[8*k +: 8]);
    endtask

    task automatic add_step(input op_e op, input logic [31:0] addr, input logic [31:0] data,
                            input bit rnd, input logic [31:0] xy, input bit done,
                            input logic [31:0] exp, input int chk);
        step_t s;
        s = '{op, addr, data, rnd, xy, done, exp, chk};
        steps_q.push_back(s);
    endtask

    task automatic run_step(input step_t s);
        logic [31:0]  data;
        logic [31:0]  exp;
        mmio_target_e tgt;
        bit           exp_busy;
        data     = s.rnd ? lcg_next() : s.data;
        tgt      = classify(s.addr);
        exp_busy = (mem_cnt != 0);
        @(posedge clk);
        read_i     <= (s.op == OP_RD) || (s.op == OP_RW);
        write_i    <= (s.op == OP_WR) || (s.op == OP_RW);
        getinst_i  <= (s.op == OP_FETCH);
        address_i  <= s.addr;
        wdata_i    <= data;
        i2c_xy_i   <= s.xy;
        i2c_done_i <= s.done;
        @(negedge clk);     // outputs settled mid cycle
        check_value("busy_o", 32'(busy_o), 32'(exp_busy));
        check_value("i2c_done_o", 32'(i2c_done_o), 32'(s.done));
        check_value("spi_busy_o", 32'(spi_busy_o), 32'(spi_active));
        if (s.chk == CHK_TABLE) begin
            check_value("rdata_o", rdata_o, s.exp);
        end else if (s.chk == CHK_MEM) begin
            exp = exp_busy ? `T08_BAD_READ : mem_model[s.addr[10:2]];
            check_value("rdata_o", rdata_o, exp);
        end
        // model update, busy targets drop requests
        if (s.op == OP_WR && tgt == TGT_MEM && !exp_busy) begin
            mem_model[s.addr[10:2]] = data;
            mem_cnt = `T08_MEM_BUSY_CYCLES;
        end else if (mem_cnt != 0) begin
            mem_cnt--;
        end
        if (s.op == OP_WR && tgt == TGT_SPI_CMD) begin
            cmd_m = data[7:0];
            cnt_m = data[11:8];
        end
        if (s.op == OP_WR && tgt == TGT_SPI_PARAM && !spi_active) begin
            model_spi_start(data);
            spi_active = 1'b1;
        end
    endtask

    // idle until the transfer ends, then compare the captured bits
    task automatic spi_wait();
        int n;
        n = 0;
        @(posedge clk);
        read_i    <= 1'b0;
        write_i   <= 1'b0;
        getinst_i <= 1'b0;
        @(negedge clk);
        while (spi_busy_o && n < SPI_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (spi_busy_o) begin
            $display("spi transfer did not end within %0d cycles", SPI_TIMEOUT);
            $display("test failed");
            $finish;
        end else begin
            for (int q = 0; q < QUIET_CYCLES; q++) begin
                @(negedge clk);
                check_value("spi_busy_o after transfer", 32'(spi_busy_o), 32'h0);
            end
            check_value("spi bit count", got_bits.size(), exp_bits.size());
            for (int i = 0; i < got_bits.size() && i < exp_bits.size(); i++)
                check_value($sformatf("spi bit %0d", i), 32'(got_bits[i]), 32'(exp_bits[i]));
            got_bits.delete();
            exp_bits.delete();
            spi_active = 1'b0;
            mem_cnt    = 0;   // window long gone
        end
    endtask

    initial begin
        lcg_state  = 32'h2d5d;
        value_errs = 0;
        proto_errs = 0;
        mem_cnt    = 0;
        spi_active = 1'b0;
        cmd_m      = '0;
        cnt_m      = '0;
        rst_n_i    <= 1'b0;
        read_i     <= 1'b0;
        write_i    <= 1'b0;
        getinst_i  <= 1'b0;
        address_i  <= '0;
        wdata_i    <= '0;
        i2c_xy_i   <= '0;
        i2c_done_i <= 1'b0;

        // memory busy window and readback
        add_step(OP_WR,    32'h040, 32'h0, 1, 32'h0, 0, 32'h0, CHK_NONE);
        add_step(OP_RD,    32'h040, 32'h0, 0, 32'h0, 0, 32'h0, CHK_MEM);  // bad read
        add_step(OP_RD,    32'h040, 32'h0, 0, 32'h0, 0, 32'h0, CHK_MEM);
        add_step(OP_RD,    32'h040, 32'h0, 0, 32'h0, 0, 32'h0, CHK_MEM);
        add_step(OP_RD,    32'h040, 32'h0, 0, 32'h0, 0, 32'h0, CHK_MEM);  // window over
        add_step(OP_FETCH, 32'h040, 32'h0, 0, 32'h0, 0, 32'h0, CHK_MEM);
        add_step(OP_WR,    32'h7fc, 32'h0, 1, 32'h0, 0, 32'h0, CHK_NONE); // top word
        add_step(OP_WR,    32'h080, 32'h0, 1, 32'h0, 0, 32'h0, CHK_NONE); // dropped, busy
        add_step(OP_IDLE,  32'h000, 32'h0, 0, 32'h0, 0, 32'h0, CHK_NONE);
        add_step(OP_IDLE,  32'h000, 32'h0, 0, 32'h0, 0, 32'h0, CHK_NONE);
        add_step(OP_IDLE,  32'h000, 32'h0, 0, 32'h0, 0, 32'h0, CHK_NONE);
        add_step(OP_FETCH, 32'h7fc, 32'h0, 0, 32'h0, 0, 32'h0, CHK_MEM);
        add_step(OP_RW,    32'h040, 32'h0, 1, 32'h0, 0, 32'h0, CHK_NONE); // no effect
        add_step(OP_RD,    32'h040, 32'h0, 0, 32'h0, 0, 32'h0, CHK_MEM);
        // touch result and unmapped space
        add_step(OP_RD,    A_I2C, 32'h0, 0, 32'h0012_0034, 1, 32'h0012_0034, CHK_TABLE);
        add_step(OP_RD,    A_I2C, 32'h0, 0, 32'h0056_0078, 0, 32'h0, CHK_TABLE);
        add_step(OP_RD,    32'h1000, 32'h0, 0, 32'h0, 0, 32'h0, CHK_TABLE);
        add_step(OP_FETCH, A_I2C, 32'h0, 0, 32'h9abc_def0, 1, 32'h9abc_def0, CHK_TABLE);
        // spi, two param bytes, then a start while busy
        add_step(OP_WR,    A_CMD,   32'h0000_02a5, 0, 32'h0, 0, 32'h0, CHK_NONE);
        add_step(OP_WR,    A_PARAM, 32'h1234_5678, 0, 32'h0, 0, 32'h0, CHK_NONE);
        add_step(OP_WR,    A_PARAM, 32'hffff_ffff, 0, 32'h0, 0, 32'h0, CHK_NONE);
        add_step(OP_SPI_WAIT, 32'h0, 32'h0, 0, 32'h0, 0, 32'h0, CHK_NONE);
        // counter 9 is capped to four bytes
        add_step(OP_WR,    A_CMD,   32'h0000_093c, 0, 32'h0, 0, 32'h0, CHK_NONE);
        add_step(OP_WR,    A_PARAM, 32'hdead_beef, 0, 32'h0, 0, 32'h0, CHK_NONE);
        add_step(OP_SPI_WAIT, 32'h0, 32'h0, 0, 32'h0, 0, 32'h0, CHK_NONE);
        add_step(OP_RW,    A_PARAM, 32'h0000_0001, 0, 32'h0, 0, 32'h0, CHK_NONE);
        add_step(OP_SPI_WAIT, 32'h0, 32'h0, 0, 32'h0, 0, 32'h0, CHK_NONE);  // no bits

        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;

        foreach (steps_q[i]) begin
            if (steps_q[i].op == OP_SPI_WAIT)
                spi_wait();
            else
                run_step(steps_q[i]);
        end

        $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/t08_tb_clk.sv ====
`timescale 1ns/1ps
`default_nettype none

// free running testbench clock, 4 ns period
module t08_tb_clk (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #2 clk_o = ~clk_o;   // half period

endmodule

`default_nettype wire

// ==== hw/t08_data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "t08_defines.svh"

module t08_data_mem (
    input  logic        clk,
    input  logic        rst_n_i,
    t08_mem_bus_if.mem  bus
);

    localparam int WORDS  = `T08_MEM_LIMIT / 4;
    localparam int IDX_W  = $clog2(WORDS);
    localparam int BUSY_W = $clog2(`T08_MEM_BUSY_CYCLES + 1);

    logic [31:0]       mem_q [WORDS];
    logic [IDX_W-1:0]  idx;
    logic [BUSY_W-1:0] busy_cnt_q;   // cycles of busy left

    assign idx = bus.address[IDX_W+1:2]; // word index, byte offset ignored

    // word store
    always_ff @(posedge clk) begin
        if (bus.write)
            mem_q[idx] <= bus.wdata;
    end

    // async read, zero when not strobed
    assign bus.rdata = bus.read ? mem_q[idx] : '0;

    // busy window after each write
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_cnt_q <= '0;
        end else if (bus.write) begin
            busy_cnt_q <= BUSY_W'(`T08_MEM_BUSY_CYCLES);
        end else if (busy_cnt_q != '0) begin
            busy_cnt_q <= busy_cnt_q - 1'b1;
        end
    end

    assign bus.busy = (busy_cnt_q != '0);

    // write only when idle, then busy for exactly the window
    a_busy_window: assert property (@(posedge clk) disable iff (!rst_n_i)
        bus.write |-> !bus.busy ##1 bus.busy [*`T08_MEM_BUSY_CYCLES] ##1 !bus.busy)
        else $error("data_mem: write while busy or wrong busy window");

endmodule

`default_nettype wire

// ==== hw/t08_defines.svh ====
`ifndef T08_DEFINES_SVH
`define T08_DEFINES_SVH

// address map
`define T08_MEM_LIMIT       2048            // below this is data memory, in bytes
`define T08_SPI_ADDR_CMD    32'd121212      // spi command + counter
`define T08_SPI_ADDR_PARAM  32'd333333      // spi parameters, starts transfer
`define T08_I2C_ADDR        32'd923923      // touch result word

// memory timing
`define T08_MEM_BUSY_CYCLES 3               // busy window after a write
`define T08_BAD_READ        32'hBAD1BAD1    // returned on read while busy

// spi transmitter limits
`define T08_SPI_MAX_BYTES   4               // parameter bytes per transfer, max

`endif

// ==== hw/t08_mem_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// decoder <-> data memory
interface t08_mem_bus_if;

    logic [31:0] address;   // byte address
    logic [31:0] wdata;
    logic        write;     // one cycle level, only when !busy
    logic        read;      // rdata valid same cycle
    logic [31:0] rdata;
    logic        busy;      // high for a few cycles after a write

    modport ctrl (
        output address, wdata, write, read,
        input  rdata, busy
    );

    modport mem (
        input  address, wdata, write, read,
        output rdata, busy
    );

endinterface

`default_nettype wire

// ==== hw/t08_mmio.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "t08_defines.svh"

module t08_mmio (
    input  logic                clk,
    input  logic                rst_n_i,
    // memory handler side
    input  logic                read_i,
    input  logic                write_i,
    input  logic                getinst_i,     // decoded like a read
    input  logic [31:0]         address_i,
    input  t08_pkg::wdata_u     wdata_i,
    // touch controller result
    input  logic [31:0]         i2c_xy_i,
    input  logic                i2c_done_i,
    output logic [31:0]         rdata_o,
    output logic                busy_o,
    output logic                i2c_done_o,
    t08_mem_bus_if.ctrl         mem,
    t08_spi_ctrl_if.ctrl        spi
);

    import t08_pkg::*;

    mmio_target_e tgt;
    logic         rd_req;       // read or fetch without write
    logic         wr_req;       // write without read or fetch
    logic         spi_start;
    logic [7:0]   spi_cmd_q;
    logic [3:0]   spi_cnt_q;

    // read+write together falls through both and does nothing
    assign rd_req = (read_i | getinst_i) & ~write_i;
    assign wr_req = write_i & ~read_i & ~getinst_i;

    // address classification
    always_comb begin
        if (address_i == `T08_I2C_ADDR)
            tgt = TGT_I2C;
        else if (address_i == `T08_SPI_ADDR_CMD)
            tgt = TGT_SPI_CMD;
        else if (address_i == `T08_SPI_ADDR_PARAM)
            tgt = TGT_SPI_PARAM;
        else if (address_i < `T08_MEM_LIMIT)
            tgt = TGT_MEM;
        else
            tgt = TGT_NONE;
    end

    // memory strobes are dropped while busy
    assign mem.read    = rd_req & (tgt == TGT_MEM) & ~mem.busy;
    assign mem.write   = wr_req & (tgt == TGT_MEM) & ~mem.busy;
    assign mem.address = ((rd_req | wr_req) && tgt == TGT_MEM) ? address_i : '0;
    assign mem.wdata   = mem.write ? wdata_i.raw : '0;

    // read mux back to handler
    always_comb begin
        rdata_o = '0; // unmapped reads give zero
        if (rd_req) begin
            case (tgt)
                TGT_I2C: rdata_o = i2c_done_i ? i2c_xy_i : '0;
                TGT_MEM: rdata_o = mem.busy ? `T08_BAD_READ : mem.rdata;
                default: rdata_o = '0;
            endcase
        end
    end

    // command and counter live here until the transmitter latches them
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            spi_cmd_q <= '0;
            spi_cnt_q <= '0;
        end else if (wr_req && tgt == TGT_SPI_CMD) begin
            spi_cmd_q <= wdata_i.spi.command;
            spi_cnt_q <= wdata_i.spi.counter;
        end
    end

    // param write starts a transfer unless tx is busy
    assign spi_start      = wr_req & (tgt == TGT_SPI_PARAM) & ~spi.busy;
    assign spi.write      = spi_start;
    assign spi.enable     = spi_start;
    assign spi.parameters = spi_start ? wdata_i.raw : '0;
    assign spi.command    = spi_cmd_q;
    assign spi.counter    = spi_cnt_q;

    assign busy_o     = mem.busy;   // only memory stalls the handler
    assign i2c_done_o = i2c_done_i;

    // a write comes without a read and leaves memory busy next cycle
    a_mem_rw_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem.write |-> !mem.read ##1 mem.busy)
        else $error("mmio: memory read with write or write not taken");

    // start only from idle and tx picks it up next cycle
    a_spi_start: assert property (@(posedge clk) disable iff (!rst_n_i)
        spi.write |-> !spi.busy ##1 spi.busy)
        else $error("mmio: spi start while busy or not taken");

endmodule

`default_nettype wire

// ==== hw/t08_mmio_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module t08_mmio_top (
    input  logic        clk,
    input  logic        rst_n_i,
    // memory handler
    input  logic        read_i,
    input  logic        write_i,
    input  logic        getinst_i,
    input  logic [31:0] address_i,
    input  logic [31:0] wdata_i,
    // touch controller
    input  logic [31:0] i2c_xy_i,
    input  logic        i2c_done_i,
    output logic [31:0] rdata_o,
    output logic        busy_o,
    output logic        i2c_done_o,
    // spi lines
    output logic        spi_busy_o,
    output logic        spi_sck_o,
    output logic        spi_mosi_o,
    output logic        spi_cs_n_o
);

    t08_mem_bus_if  mem_bus ();
    t08_spi_ctrl_if spi_ctrl ();

    // decoder, raw wdata lands on the union port
    t08_mmio u_mmio (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .read_i     (read_i),
        .write_i    (write_i),
        .getinst_i  (getinst_i),
        .address_i  (address_i),
        .wdata_i    (wdata_i),
        .i2c_xy_i   (i2c_xy_i),
        .i2c_done_i (i2c_done_i),
        .rdata_o    (rdata_o),
        .busy_o     (busy_o),
        .i2c_done_o (i2c_done_o),
        .mem        (mem_bus.ctrl),
        .spi        (spi_ctrl.ctrl)
    );

    t08_data_mem u_data_mem (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (mem_bus.mem)
    );

    t08_spi_tx u_spi_tx (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ctrl       (spi_ctrl.tx),
        .spi_sck_o  (spi_sck_o),
        .spi_mosi_o (spi_mosi_o),
        .spi_cs_n_o (spi_cs_n_o)
    );

    assign spi_busy_o = spi_ctrl.busy; // transfer in flight

endmodule

`default_nettype wire

// ==== hw/t08_pkg.sv ====
`default_nettype none

package t08_pkg;

    // which target a request lands on
    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_MEM,
        TGT_SPI_CMD,
        TGT_SPI_PARAM,
        TGT_I2C
    } mmio_target_e;

    // spi command register layout
    typedef struct packed {
        logic [19:0] unused;    // ignored
        logic [3:0]  counter;   // number of parameter bytes
        logic [7:0]  command;   // first byte on the wire
    } spi_cmd_word_t;

    // write word, raw for memory and spi params, fields for spi command
    typedef union packed {
        logic [31:0]   raw;
        spi_cmd_word_t spi;
    } wdata_u;

endpackage

`default_nettype wire

// ==== hw/t08_spi_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// decoder <-> spi transmitter
interface t08_spi_ctrl_if;

    logic [7:0]  command;       // held in decoder registers
    logic [3:0]  counter;       // parameter byte count
    logic [31:0] parameters;    // valid with write/enable only
    logic        write;
    logic        enable;
    logic        busy;          // transfer in progress

    modport ctrl (
        output command, counter, parameters, write, enable,
        input  busy
    );

    modport tx (
        input  command, counter, parameters, write, enable,
        output busy
    );

endinterface

`default_nettype wire

// ==== hw/t08_spi_tx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "t08_defines.svh"

module t08_spi_tx (
    input  logic        clk,
    input  logic        rst_n_i,
    t08_spi_ctrl_if.tx  ctrl,
    output logic        spi_sck_o,
    output logic        spi_mosi_o,
    output logic        spi_cs_n_o
);

    logic        start;
    logic        bit_end;       // second half of a bit
    logic        last_bit;
    logic        next_byte;
    logic        done;
    logic [2:0]  nbytes;        // capped counter

    logic        busy_q;
    logic        cs_n_q;
    logic        phase_q;       // clock divider that doubles as sck
    logic [2:0]  bit_cnt_q;     // bits left in current byte
    logic [2:0]  bytes_left_q;  // param bytes still to send
    logic [7:0]  shift_q;
    logic [31:0] param_q;       // remaining params with byte 0 at bottom

    assign start     = ctrl.write & ctrl.enable & ~busy_q;
    assign bit_end   = busy_q & phase_q;
    assign last_bit  = (bit_cnt_q == 3'd0);
    assign next_byte = bit_end & last_bit & (bytes_left_q != 3'd0);
    assign done      = bit_end & last_bit & (bytes_left_q == 3'd0);

    assign nbytes = (ctrl.counter > `T08_SPI_MAX_BYTES) ? 3'(`T08_SPI_MAX_BYTES)
                                                        : ctrl.counter[2:0];

    // control path
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q       <= 1'b0;
            cs_n_q       <= 1'b1;   // deselected
            phase_q      <= 1'b0;
            bit_cnt_q    <= '0;
            bytes_left_q <= '0;
        end else if (start) begin
            busy_q       <= 1'b1;
            cs_n_q       <= 1'b0;
            phase_q      <= 1'b0;
            bit_cnt_q    <= 3'd7;
            bytes_left_q <= nbytes;
        end else if (busy_q) begin
            phase_q <= ~phase_q;    // two clocks per bit
            if (done) begin
                busy_q <= 1'b0;
                cs_n_q <= 1'b1;
            end else if (next_byte) begin
                bit_cnt_q    <= 3'd7;
                bytes_left_q <= bytes_left_q - 1'b1;
            end else if (bit_end) begin
                bit_cnt_q <= bit_cnt_q - 1'b1;
            end
        end
    end

    // data path
    always_ff @(posedge clk) begin
        if (start) begin
            shift_q <= ctrl.command;    // command goes first
            param_q <= ctrl.parameters;
        end else if (next_byte) begin
            shift_q <= param_q[7:0];
            param_q <= param_q >> 8;
        end else if (bit_end && !last_bit) begin
            shift_q <= shift_q << 1;    // msb first
        end
    end

    assign ctrl.busy  = busy_q;
    assign spi_sck_o  = phase_q;             // rises mid bit
    assign spi_mosi_o = busy_q & shift_q[7];
    assign spi_cs_n_o = cs_n_q;

    // deselected means no transfer and sck parked low
    a_cs_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        spi_cs_n_o |-> !busy_q && !spi_sck_o)
        else $error("spi_tx: chip select high while busy or sck not idle");

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hw
hw/t08_pkg.sv
hw/t08_mem_bus_if.sv
hw/t08_spi_ctrl_if.sv
hw/t08_mmio.sv
hw/t08_data_mem.sv
hw/t08_spi_tx.sv
hw/t08_mmio_top.sv
dv/t08_tb_clk.sv
dv/t08_mmio_tb.sv
